// ==== hdl/sdram_pkg.sv ====
//######################################################################
// sdram_pkg
// shared geometry, timing, command codes and bus structs for the
// four-bank SDR SDRAM controller (16-bit, 32 MB, CL2, burst of 4)
//######################################################################
`default_nettype none

package sdram_pkg;

    // geometry
    localparam int NBANK = 4;
    localparam int ROW_W = 13;
    localparam int COL_W = 9;
    localparam int AW    = ROW_W + COL_W;   // row and column, bank is the port index
    localparam int DW    = 16;

    // timing in clock cycles
    localparam int T_RCD        = 2;    // activate to read/write
    localparam int T_RP         = 2;    // precharge to activate
    localparam int CAS_LAT      = 2;
    localparam int BURST        = 4;    // read burst length in words
    localparam int T_RRD        = 2;    // activate to activate, any bank
    localparam int REF_INTERVAL = 390;
    localparam int T_RFC        = 7;    // refresh recovery

    // one-hot bank states, indices derived from the timing above
    localparam int ST_IDLE    = 0;
    localparam int ST_PRE_ACT = T_RP;               // state 1 waits out tRP
    localparam int ST_ACT     = ST_PRE_ACT + 1;
    localparam int ST_PRE_RD  = ST_ACT + T_RCD;
    localparam int ST_READ    = ST_PRE_RD + 1;      // command on the pins here
    localparam int ST_DST     = ST_READ + CAS_LAT + 1;  // first word on dout
    localparam int ST_RDY     = ST_DST + BURST - 1;
    localparam int STW        = ST_RDY + 1;

    // ends of the busy windows, all starting at ST_READ
    localparam int ST_DBUSY_END  = ST_READ + BURST - 2;           // next read blocked
    localparam int ST_BUSY64_END = ST_READ + CAS_LAT + BURST - 2; // writes blocked
    localparam int ST_DQM_END    = ST_READ + CAS_LAT - 1;

    //                                  /CS /RAS /CAS /WE
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_NOP       = 4'b0111;

    // all zero when the source is not issuing, so sources merge by OR
    typedef struct packed {
        logic [3:0]       cmd;
        logic [1:0]       ba;
        logic [ROW_W-1:0] a;
    } sdram_cmd_t;

    typedef struct packed {
        logic [AW-1:0] addr;    // {row, col}
        logic          rd;
        logic          wr;
        logic [DW-1:0] wdata;
    } bank_req_t;

    typedef struct packed {
        logic br;       // bus request
        logic dbusy;    // DQ taken by read data
        logic dbusy64;  // DQ taken for the whole burst
        logic dqm_busy;
        logic post_act; // inside tRRD
        logic idle;
    } bank_stat_t;

endpackage

`default_nettype wire

// ==== hdl/sdram_bank.sv ====
//######################################################################
// sdram_bank
// per-bank controller: tracks the open row, picks precharge,
// activate or read/write, and walks a one-hot state ring through
// the read burst. shares the command bus, DQ and tRRD with the rest
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_bank (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [1:0]               bank_id,
    input  sdram_pkg::bank_req_t    req,
    input  wire                     gnt,
    input  wire                     set_prech,     // precharge-all from refresh
    input  wire                     all_dbusy,
    input  wire                     all_dbusy64,
    input  wire                     all_dqm,
    input  wire                     all_act,
    output sdram_pkg::bank_stat_t   stat,
    output logic                    ack,
    output logic                    dst,
    output logic                    dok,
    output logic                    rdy,
    output sdram_pkg::sdram_cmd_t   bus
);

    logic [sdram_pkg::STW-1:0]   st, next_st, rot_st;
    logic [sdram_pkg::ROW_W-1:0] row;           // open row
    logic [sdram_pkg::ROW_W-1:0] addr_row;
    logic [sdram_pkg::COL_W-1:0] addr_col;
    logic [sdram_pkg::T_RRD-2:0] last_act;
    logic prechd, actd;
    logic rd_wr, row_hit, need_prech, need_act;
    logic can_act, can_rw;
    logic do_prech, do_act, do_rw;

    assign addr_row = req.addr[sdram_pkg::AW-1:sdram_pkg::COL_W];
    assign addr_col = req.addr[sdram_pkg::COL_W-1:0];
    assign rd_wr    = req.rd | req.wr;

    // what the bank needs before the access
    assign row_hit    = actd && (row == addr_row);
    assign need_prech = !prechd && !row_hit;    // also true out of reset
    assign need_act   = prechd && !actd;

    // shared resources free?
    assign can_act = !all_act && !all_dqm;
    assign can_rw  = !all_dbusy && !all_dqm && (!all_dbusy64 || req.rd);  // writes need it all

    // gnt only arrives when br was set, so these never fail on resources
    always_comb begin
        do_prech = gnt && st[sdram_pkg::ST_IDLE] && rd_wr && need_prech;
        do_act   = gnt && can_act &&
                   ((st[sdram_pkg::ST_IDLE] && rd_wr && need_act) ||
                    st[sdram_pkg::ST_PRE_ACT]);
        do_rw    = gnt && can_rw &&
                   ((st[sdram_pkg::ST_IDLE] && rd_wr && row_hit) ||
                    st[sdram_pkg::ST_PRE_RD]);
    end

    // request the bus only when the next command could go out
    always_comb begin
        stat.br = 1'b0;
        if (st[sdram_pkg::ST_IDLE] && rd_wr)
            stat.br = need_prech || (need_act && can_act) || (row_hit && can_rw);
        if (st[sdram_pkg::ST_PRE_ACT])
            stat.br = can_act;
        if (st[sdram_pkg::ST_PRE_RD])
            stat.br = can_rw;
    end

    always_comb begin
        rot_st  = {st[sdram_pkg::STW-2:0], st[sdram_pkg::STW-1]};
        next_st = st;
        if (do_prech)
            next_st = rot_st;                       // into the tRP wait
        if (do_act)
            next_st = '0;
        if (do_act)
            next_st[sdram_pkg::ST_ACT] = 1'b1;
        if (do_rw) begin
            next_st = '0;
            next_st[sdram_pkg::ST_READ] = 1'b1;
        end
        // timed states just move on
        if (!st[sdram_pkg::ST_IDLE] && !st[sdram_pkg::ST_PRE_ACT] &&
            !st[sdram_pkg::ST_PRE_RD])
            next_st = rot_st;
        if (st[sdram_pkg::ST_READ] && req.wr) begin
            next_st = '0;                           // single write done
            next_st[sdram_pkg::ST_IDLE] = 1'b1;
        end
    end

    // user handshake
    assign ack = st[sdram_pkg::ST_READ];
    assign dst = st[sdram_pkg::ST_DST] | (st[sdram_pkg::ST_READ] & req.wr);
    assign rdy = st[sdram_pkg::ST_RDY] | (st[sdram_pkg::ST_READ] & req.wr);
    assign dok = |st[sdram_pkg::ST_RDY:sdram_pkg::ST_DST];   // 4 burst words

    // status back to the arbiter
    assign stat.dbusy    = |st[sdram_pkg::ST_DBUSY_END:sdram_pkg::ST_READ];
    assign stat.dbusy64  = |st[sdram_pkg::ST_BUSY64_END:sdram_pkg::ST_READ];
    assign stat.dqm_busy = |st[sdram_pkg::ST_DQM_END:sdram_pkg::ST_READ];
    assign stat.post_act = |last_act;
    assign stat.idle     = st[sdram_pkg::ST_IDLE];

    // command out, zero unless issuing
    always_comb begin
        bus = '0;
        if (do_prech) begin
            bus.cmd = sdram_pkg::CMD_PRECHARGE;     // A10 low, this bank only
            bus.ba  = bank_id;
        end else if (do_act) begin
            bus.cmd = sdram_pkg::CMD_ACTIVE;
            bus.ba  = bank_id;
            bus.a   = addr_row;
        end else if (do_rw) begin
            bus.cmd = req.rd ? sdram_pkg::CMD_READ : sdram_pkg::CMD_WRITE;
            bus.ba  = bank_id;
            bus.a   = {{(sdram_pkg::ROW_W-sdram_pkg::COL_W){1'b0}}, addr_col};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= '0;
            st[0]    <= 1'b1;   // idle
            prechd   <= 1'b0;   // unknown row, precharge first
            actd     <= 1'b0;
            last_act <= '0;
        end else begin
            st       <= next_st;
            last_act <= (sdram_pkg::T_RRD-1)'({last_act, do_act});
            if (do_act) begin
                prechd <= 1'b0;
                actd   <= 1'b1;
            end
            if (do_prech || set_prech) begin
                prechd <= 1'b1;
                actd   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_act)
            row <= addr_row;
    end

endmodule

`default_nettype wire

// ==== hdl/sdram_bus_arbiter.sv ====
//######################################################################
// sdram_bus_arbiter
// round-robin grant of the command bus among the banks, refresh has
// priority. ORs the command buses onto registered pins and reduces
// the bank status flags
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_bus_arbiter (
    input  wire                                            clk,
    input  wire                                            rst,
    input  sdram_pkg::bank_stat_t [sdram_pkg::NBANK-1:0]   stat,
    input  sdram_pkg::sdram_cmd_t [sdram_pkg::NBANK-1:0]   bank_bus,
    input  sdram_pkg::sdram_cmd_t                          ref_bus,
    input  wire                                            ref_busy,
    output logic [sdram_pkg::NBANK-1:0]                    gnt,
    output logic                                           all_dbusy,
    output logic                                           all_dbusy64,
    output logic                                           all_dqm,
    output logic                                           all_act,
    output logic [3:0]                                     cmd,
    output logic [1:0]                                     ba,
    output logic [sdram_pkg::ROW_W-1:0]                    a
);

    localparam int PW = $clog2(sdram_pkg::NBANK);

    logic [PW-1:0]         ptr;         // first bank to look at
    logic [PW-1:0]         idx, gnt_idx;
    logic                  found;
    sdram_pkg::sdram_cmd_t bank_or, merged;

    always_comb begin
        gnt     = '0;
        gnt_idx = ptr;
        found   = 1'b0;
        idx     = ptr;
        for (int i = 0; i < sdram_pkg::NBANK; i++) begin
            idx = ptr + PW'(i);
            if (!found && !ref_busy && stat[idx].br) begin
                gnt[idx] = 1'b1;
                gnt_idx  = idx;
                found    = 1'b1;
            end
        end
    end

    // status reduction, every bank sees the same flags
    always_comb begin
        all_dbusy   = 1'b0;
        all_dbusy64 = 1'b0;
        all_dqm     = 1'b0;
        all_act     = 1'b0;
        bank_or     = '0;
        for (int i = 0; i < sdram_pkg::NBANK; i++) begin
            all_dbusy   |= stat[i].dbusy;
            all_dbusy64 |= stat[i].dbusy64;
            all_dqm     |= stat[i].dqm_busy;
            all_act     |= stat[i].post_act;
            bank_or     |= bank_bus[i];
        end
        merged = bank_or | ref_bus;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
            cmd <= sdram_pkg::CMD_NOP;
        end else begin
            if (bank_or.cmd != 4'd0)
                ptr <= gnt_idx + 1'b1;  // move past the bank just served
            cmd <= (merged.cmd == 4'd0) ? sdram_pkg::CMD_NOP : merged.cmd;
        end
    end

    always_ff @(posedge clk) begin
        ba <= merged.ba;
        a  <= merged.a;
    end

endmodule

`default_nettype wire

// ==== hdl/sdram_refresh.sv ====
//######################################################################
// sdram_refresh
// interval timer; on expiry waits for all banks idle, then issues
// precharge-all, waits tRP, issues auto-refresh and holds off for tRFC
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_refresh (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    all_idle,
    output logic                   ref_busy,
    output logic                   set_prech,
    output sdram_pkg::sdram_cmd_t  bus
);

    localparam int IW = $clog2(sdram_pkg::REF_INTERVAL);
    localparam int TW = $clog2(sdram_pkg::T_RFC + 1);

    typedef enum logic [1:0] {RF_IDLE, RF_RP, RF_REF, RF_RFC} rf_state_t;

    rf_state_t     st;
    logic [IW-1:0] icnt;
    logic [TW-1:0] tmr;
    logic          pend, issue_pre;

    assign issue_pre = pend && all_idle && (st == RF_IDLE);
    assign ref_busy  = issue_pre || (st != RF_IDLE);   // masks bank grants
    assign set_prech = issue_pre;

    always_comb begin
        bus = '0;
        if (issue_pre) begin
            bus.cmd   = sdram_pkg::CMD_PRECHARGE;
            bus.a[10] = 1'b1;       // all banks
        end else if (st == RF_REF) begin
            bus.cmd = sdram_pkg::CMD_REFRESH;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= RF_IDLE;
            icnt <= IW'(sdram_pkg::REF_INTERVAL - 1);
            tmr  <= '0;
            pend <= 1'b0;
        end else begin
            icnt <= (icnt == '0) ? IW'(sdram_pkg::REF_INTERVAL - 1) : icnt - 1'b1;
            if (icnt == '0)
                pend <= 1'b1;
            case (st)
                RF_IDLE: if (issue_pre) begin
                    pend <= 1'b0;
                    st   <= RF_RP;
                    tmr  <= TW'(sdram_pkg::T_RP - 1);
                end
                RF_RP: begin
                    tmr <= tmr - 1'b1;
                    if (tmr <= 1)
                        st <= RF_REF;
                end
                RF_REF: begin
                    st  <= RF_RFC;
                    tmr <= TW'(sdram_pkg::T_RFC - 1);
                end
                default: begin  // tRFC hold
                    tmr <= tmr - 1'b1;
                    if (tmr <= 1)
                        st <= RF_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdram_ctrl.sv ====
//######################################################################
// sdram_ctrl
// top of the four-bank SDRAM controller: bank controllers, bus
// arbiter, refresh scheduler and the DQ read/write registers
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl (
    input  wire                                          clk,
    input  wire                                          rst,
    input  sdram_pkg::bank_req_t [sdram_pkg::NBANK-1:0]  req,
    input  wire  [sdram_pkg::DW-1:0]                     dq_in,
    output logic [sdram_pkg::NBANK-1:0]                  ack,
    output logic [sdram_pkg::NBANK-1:0]                  dst,
    output logic [sdram_pkg::NBANK-1:0]                  dok,
    output logic [sdram_pkg::NBANK-1:0]                  rdy,
    output logic [sdram_pkg::DW-1:0]                     dout,
    output logic [sdram_pkg::DW-1:0]                     dq_out,
    output logic                                         dq_oe,
    output logic [3:0]                                   cmd,
    output logic [1:0]                                   ba,
    output logic [sdram_pkg::ROW_W-1:0]                  a
);

    sdram_pkg::bank_stat_t [sdram_pkg::NBANK-1:0] stat;
    sdram_pkg::sdram_cmd_t [sdram_pkg::NBANK-1:0] bank_bus;
    sdram_pkg::sdram_cmd_t                        ref_bus;
    logic [sdram_pkg::NBANK-1:0] gnt, idle_v;
    logic [sdram_pkg::DW-1:0]    wdata_sel;
    logic all_dbusy, all_dbusy64, all_dqm, all_act;
    logic ref_busy, set_prech, wr_issue;

    for (genvar b = 0; b < sdram_pkg::NBANK; b++) begin : g_bank
        sdram_bank bank_inst (
            .clk, .rst,
            .bank_id     (2'(b)),
            .req         (req[b]),
            .gnt         (gnt[b]),
            .set_prech, .all_dbusy, .all_dbusy64, .all_dqm, .all_act,
            .stat        (stat[b]),
            .ack         (ack[b]),
            .dst         (dst[b]),
            .dok         (dok[b]),
            .rdy         (rdy[b]),
            .bus         (bank_bus[b])
        );
        assign idle_v[b] = stat[b].idle;
    end

    sdram_bus_arbiter arb_inst (
        .clk, .rst, .stat, .bank_bus, .ref_bus, .ref_busy, .gnt,
        .all_dbusy, .all_dbusy64, .all_dqm, .all_act, .cmd, .ba, .a
    );

    sdram_refresh ref_inst (
        .clk, .rst,
        .all_idle  (&idle_v),
        .ref_busy, .set_prech,
        .bus       (ref_bus)
    );

    // write data of the bank issuing a write, one at most
    always_comb begin
        wr_issue  = 1'b0;
        wdata_sel = '0;
        for (int i = 0; i < sdram_pkg::NBANK; i++) begin
            if (bank_bus[i].cmd == sdram_pkg::CMD_WRITE) begin
                wr_issue  = 1'b1;
                wdata_sel = req[i].wdata;
            end
        end
    end

    // dq_oe lines up with the registered write command
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dq_oe <= 1'b0;
        else
            dq_oe <= wr_issue;
    end

    always_ff @(posedge clk) begin
        dq_out <= wdata_sel;
        dout   <= dq_in;    // read capture
    end

endmodule

`default_nettype wire

// ==== verification/sdram_model.sv ====
//######################################################################
// sdram_model
// behavioural SDR SDRAM: four banks with open-row tracking, CAS
// latency 2, sequential read burst of four, single-word writes.
// flags commands that break the bank state rules
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_model (
    input  wire                         clk,
    input  wire  [3:0]                  cmd,
    input  wire  [1:0]                  ba,
    input  wire  [sdram_pkg::ROW_W-1:0] a,
    input  wire  [sdram_pkg::DW-1:0]    dq_wr,
    input  wire                         dq_oe,
    output logic [sdram_pkg::DW-1:0]    dq_rd,
    output int                          err_cnt,
    output int                          ref_cnt
);

    logic [15:0] mem [int];         // sparse, only written cells
    logic [3:0]  open_bank;
    logic [12:0] open_row [4];
    logic        rd_on;             // burst in progress
    logic [1:0]  rd_ba, rd_beat;
    logic [12:0] rd_row;
    logic [8:0]  rd_col;

    // unwritten cells hold a pattern of the full address
    function automatic logic [15:0] read_cell(input logic [23:0] key);
        if (mem.exists(int'(key)))
            return mem[int'(key)];
        return key[15:0] ^ {2{key[23:16]}};
    endfunction

    task automatic bad_cmd(input string what);
        err_cnt++;
        $display("sdram model error at %0t ns: %s", $time, what);
    endtask

    initial begin
        err_cnt   = 0;
        ref_cnt   = 0;
        open_bank = '0;
        rd_on     = 1'b0;
        rd_beat   = '0;
        dq_rd     = '0;
    end

    always @(posedge clk) begin
        if (rd_on) begin
            // sequential burst wraps inside the aligned group of four
            dq_rd   <= read_cell({rd_ba, rd_row, rd_col[8:2], rd_col[1:0] + rd_beat});
            rd_beat <= rd_beat + 1'b1;
            if (rd_beat == 2'd3)
                rd_on <= 1'b0;
        end else begin
            dq_rd <= 'x;
        end
        if (dq_oe && cmd != sdram_pkg::CMD_WRITE)
            bad_cmd("DQ driven outside a write command");
        case (cmd)
            sdram_pkg::CMD_ACTIVE: begin
                if (open_bank[ba])
                    bad_cmd($sformatf("activate on bank %0d without precharge", ba));
                open_bank[ba] <= 1'b1;
                open_row[ba]  <= a;
            end
            sdram_pkg::CMD_PRECHARGE: begin
                if (a[10])
                    open_bank <= '0;            // precharge all
                else
                    open_bank[ba] <= 1'b0;
            end
            sdram_pkg::CMD_READ: begin
                if (!open_bank[ba])
                    bad_cmd($sformatf("read from closed bank %0d", ba));
                rd_on   <= 1'b1;                // first word one cycle on, CL2
                rd_beat <= '0;
                rd_ba   <= ba;
                rd_row  <= open_row[ba];
                rd_col  <= a[8:0];
            end
            sdram_pkg::CMD_WRITE: begin
                if (!open_bank[ba])
                    bad_cmd($sformatf("write to closed bank %0d", ba));
                if (!dq_oe)
                    bad_cmd("write command without DQ driven");
                mem[int'({ba, open_row[ba], a[8:0]})] = dq_wr;
            end
            sdram_pkg::CMD_REFRESH: begin
                if (open_bank != '0)
                    bad_cmd("refresh while a bank is still open");
                ref_cnt++;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verification/sdram_ctrl_sva.sv ====
//######################################################################
// sdram_ctrl_sva
// bus arbiter properties: one-hot grant, no bank grant during
// refresh, activate spacing on the command pins
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl_sva (
    input wire                        clk,
    input wire                        rst,
    input wire [sdram_pkg::NBANK-1:0] gnt,
    input wire                        ref_busy,
    input wire [3:0]                  cmd
);

    int n_onehot = 0;
    int n_ref    = 0;
    int n_rrd    = 0;
    int fail_cnt;
    int since_act;      // cycles since the last activate, saturating

    assign fail_cnt = n_onehot + n_ref + n_rrd;

    always @(posedge clk or posedge rst) begin
        if (rst)
            since_act <= sdram_pkg::T_RRD;
        else if (cmd == sdram_pkg::CMD_ACTIVE)
            since_act <= 0;
        else if (since_act < sdram_pkg::T_RRD)
            since_act <= since_act + 1;
    end

    gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else begin
            n_onehot++;
            $error("more than one bank granted");
        end

    gnt_vs_refresh: assert property (@(posedge clk) disable iff (rst)
        ref_busy |-> (gnt == '0))
        else begin
            n_ref++;
            $error("bank granted while refresh owns the bus");
        end

    act_spacing: assert property (@(posedge clk) disable iff (rst)
        (cmd == sdram_pkg::CMD_ACTIVE) |-> (since_act >= sdram_pkg::T_RRD - 1))
        else begin
            n_rrd++;
            $error("two activates closer than tRRD");
        end

endmodule

bind sdram_bus_arbiter sdram_ctrl_sva sva_inst (
    .clk      (clk),
    .rst      (rst),
    .gnt      (gnt),
    .ref_busy (ref_busy),
    .cmd      (cmd)
);

`default_nettype wire

// ==== verification/sdram_ctrl_tb.sv ====
//######################################################################
// sdram_ctrl_tb
// testbench for the four-bank SDRAM controller: a table of reads and
// writes on the bank ports, some launched together, a reference
// memory for the read data and checks on the read/write handshake
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl_tb;

    localparam int NENT  = 22;
    localparam int NPASS = 4;      // enough traffic to cross a refresh
    localparam int LIMIT = NENT * NPASS * 400 + 2 * sdram_pkg::REF_INTERVAL + 10;

    typedef struct packed {
        logic [1:0]  bank;
        logic [12:0] row;
        logic [8:0]  col;
        logic [1:0]  op;        // 0 read, 1 write data, 2 write random
        logic        par;       // goes out together with the next entry
        logic [15:0] data;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    sdram_pkg::bank_req_t [sdram_pkg::NBANK-1:0] req;
    logic [sdram_pkg::NBANK-1:0] ack, dst, dok, rdy;
    logic [15:0] dq_in, dout, dq_out;
    logic        dq_oe;
    logic [3:0]  cmd;
    logic [1:0]  ba;
    logic [12:0] a;
    int model_errs, refreshes;
    int errors = 0;
    int cycles = 0;
    entry_t tbl [NENT];
    logic [15:0] ref_mem [int];     // words written so far

    sdram_ctrl sdram_ctrl_inst (
        .clk, .rst, .req, .dq_in, .ack, .dst, .dok, .rdy,
        .dout, .dq_out, .dq_oe, .cmd, .ba, .a
    );

    sdram_model model_inst (
        .clk, .cmd, .ba, .a, .dq_oe,
        .dq_wr   (dq_out),
        .dq_rd   (dq_in),
        .err_cnt (model_errs),
        .ref_cnt (refreshes)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, a request was never served", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic entry_t ent(input int bank, input int row, input int col,
                                   input int op, input bit par, input logic [15:0] data);
        entry_t e;
        e.bank = 2'(bank);
        e.row  = 13'(row);
        e.col  = 9'(col);
        e.op   = 2'(op);
        e.par  = par;
        e.data = data;
        return e;
    endfunction

    // memory content before any write, from the full address
    function automatic logic [15:0] initial_word(input logic [23:0] key);
        return key[15:0] ^ {2{key[23:16]}};
    endfunction

    function automatic logic [15:0] expected_word(input logic [23:0] key);
        if (ref_mem.exists(int'(key)))
            return ref_mem[int'(key)];
        return initial_word(key);
    endfunction

    // column of burst word w, sequential order inside four
    function automatic logic [8:0] burst_col(input logic [8:0] col, input int w);
        logic [1:0] lo;
        lo = col[1:0] + 2'(w);
        return {col[8:2], lo};
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic load_table();
        tbl[0]  = ent(0, 5, 8, 1, 0, 16'ha5a5);     // row miss out of reset
        tbl[1]  = ent(0, 5, 8, 0, 0, 16'h0);        // read back, word 0
        tbl[2]  = ent(0, 5, 9, 2, 0, 16'h0);
        tbl[3]  = ent(0, 5, 10, 2, 0, 16'h0);
        tbl[4]  = ent(0, 5, 8, 0, 0, 16'h0);
        tbl[5]  = ent(0, 77, 8, 0, 0, 16'h0);       // other row, open bank
        tbl[6]  = ent(0, 77, 3, 1, 0, 16'h1234);
        tbl[7]  = ent(0, 5, 11, 0, 0, 16'h0);       // burst wraps to col 8
        tbl[8]  = ent(0, 200, 0, 2, 1, 16'h0);      // four banks at once
        tbl[9]  = ent(1, 200, 0, 2, 1, 16'h0);
        tbl[10] = ent(2, 9, 4, 2, 1, 16'h0);
        tbl[11] = ent(3, 8191, 511, 2, 0, 16'h0);
        tbl[12] = ent(0, 200, 0, 0, 1, 16'h0);
        tbl[13] = ent(1, 200, 0, 0, 1, 16'h0);
        tbl[14] = ent(2, 9, 4, 0, 1, 16'h0);
        tbl[15] = ent(3, 8191, 511, 0, 0, 16'h0);
        tbl[16] = ent(1, 3, 40, 1, 1, 16'hbeef);    // reads and writes mixed
        tbl[17] = ent(2, 9, 5, 0, 1, 16'h0);
        tbl[18] = ent(3, 1, 1, 2, 1, 16'h0);
        tbl[19] = ent(0, 77, 3, 0, 0, 16'h0);
        tbl[20] = ent(1, 3, 40, 0, 0, 16'h0);
        tbl[21] = ent(3, 1, 0, 0, 0, 16'h0);
    endtask

    // one request on its bank port, through to the end of the handshake
    task automatic access(input int k);
        entry_t      e;
        int          b, lat;
        logic [15:0] wdata;
        logic [15:0] exp [4];
        e     = tbl[k];
        b     = int'(e.bank);
        wdata = (e.op == 2'd2) ? 16'($urandom) : e.data;
        @(posedge clk);
        #1;
        req[b].addr  = {e.row, e.col};
        req[b].wdata = wdata;
        req[b].rd    = (e.op == 2'd0);
        req[b].wr    = (e.op != 2'd0);
        @(negedge clk);
        while (!ack[b])
            @(negedge clk);             // held until ack, global timeout
        if (e.op != 2'd0) begin
            check($sformatf("bank %0d write dst", b), 32'(dst[b]), 1);
            check($sformatf("bank %0d write rdy", b), 32'(rdy[b]), 1);
            ref_mem[int'({e.bank, e.row, e.col})] = wdata;
        end else begin
            for (int w = 0; w < 4; w++)
                exp[w] = expected_word({e.bank, e.row, burst_col(e.col, w)});
        end
        @(posedge clk);
        #1;
        req[b].rd = 1'b0;
        req[b].wr = 1'b0;
        @(negedge clk);
        check($sformatf("bank %0d ack one cycle", b), 32'(ack[b]), 0);
        if (e.op == 2'd0) begin
            lat = 1;
            while (!dst[b] && lat < 8) begin
                @(negedge clk);
                lat++;
            end
            check($sformatf("bank %0d ack to dst", b), lat, sdram_pkg::CAS_LAT + 1);
            for (int w = 0; w < sdram_pkg::BURST; w++) begin
                check($sformatf("bank %0d dok word %0d", b, w), 32'(dok[b]), 1);
                check($sformatf("bank %0d rdy word %0d", b, w), 32'(rdy[b]), 32'(w == 3));
                check($sformatf("bank %0d row %0d col %0d word %0d", b, e.row, e.col, w),
                      32'(dout), 32'(exp[w]));
                @(negedge clk);
            end
            check($sformatf("bank %0d dok after burst", b), 32'(dok[b]), 0);
        end
    endtask

    initial begin
        int k, n, total;
        void'($urandom(32'h1a7e9de4));
        rst = 1'b1;
        req = '0;
        load_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int p = 0; p < NPASS; p++) begin
            k = 0;
            while (k < NENT) begin
                n = 1;
                while (tbl[k + n - 1].par && (k + n < NENT) && (n < 4))
                    n++;                // group of entries on different banks
                fork
                    access(k);
                    if (n > 1) access(k + 1);
                    if (n > 2) access(k + 2);
                    if (n > 3) access(k + 3);
                join
                k += n;
            end
        end
        repeat (20) @(posedge clk);
        check("refresh commands seen", 32'(refreshes > 0), 1);
        total = errors + model_errs + sdram_ctrl_inst.arb_inst.sva_inst.fail_cnt;
        $display("errors: %0d checks, %0d memory model, %0d assertions, %0d cycles",
                 errors, model_errs, sdram_ctrl_inst.arb_inst.sva_inst.fail_cnt, cycles);
        if (total == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/sdram_pkg.sv
hdl/sdram_bank.sv
hdl/sdram_bus_arbiter.sv
hdl/sdram_refresh.sv
hdl/sdram_ctrl.sv
verification/sdram_model.sv
verification/sdram_ctrl_sva.sv
verification/sdram_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= sdram_ctrl_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIMARGS   ?= +verilator+error+limit+1000
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
